// ==== cluster_bridge_pkg.sv ====
// ============================
// Widths and depths shared by the SoC to cluster bridge
// Imported by every bridge stage and by the testbench
// ============================
`default_nettype none

package cluster_bridge_pkg;

  // Transaction IDs on both sides
  localparam int unsigned SocIdWidth     = 6;
  localparam int unsigned ClusterIdWidth = 2;

  // Remap table
  // One entry per cluster ID so MaxUniqIds equals 2**ClusterIdWidth
  localparam int unsigned MaxUniqIds   = 4;
  localparam int unsigned MaxTxnsPerId = 4;
  localparam int unsigned TxnCntWidth  = $clog2(MaxTxnsPerId + 1);

  // Isolation stage
  localparam int unsigned MaxPending   = 8;
  localparam int unsigned PendCntWidth = $clog2(MaxPending + 1);

  // Payload
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Async FIFOs with gray pointers one bit wider than the slot index
  localparam int unsigned LogDepth  = 3;
  localparam int unsigned FifoDepth = 2 ** LogDepth;
  localparam int unsigned PtrWidth  = LogDepth + 1;

  // Request word {cluster id, we, addr, wdata}
  localparam int unsigned ReqWordWidth = ClusterIdWidth + 1 + AddrWidth + DataWidth;

  // Response word {cluster id, err, rdata}
  localparam int unsigned RspWordWidth = ClusterIdWidth + 1 + DataWidth;

endpackage

`default_nettype wire

// ==== bridge_bus_if.sv ====
// ============================
// Valid/ready request and response bundle between bridge stages
// IdWidth selects the SoC or the cluster ID width
// ============================
`timescale 1ns/1ps
`default_nettype none

interface bridge_bus_if
  import cluster_bridge_pkg::*;
#(
  parameter int unsigned IdWidth = SocIdWidth
) ();

  // Request channel
  logic                 req_valid;
  logic                 req_ready;
  logic [IdWidth-1:0]   req_id;
  logic                 req_we;
  logic [AddrWidth-1:0] req_addr;
  logic [DataWidth-1:0] req_wdata;

  // Response channel
  logic                 rsp_valid;
  logic                 rsp_ready;
  logic [IdWidth-1:0]   rsp_id;
  logic [DataWidth-1:0] rsp_rdata;
  logic                 rsp_err;

  modport mst (
    output req_valid, req_id, req_we, req_addr, req_wdata, rsp_ready,
    input  req_ready, rsp_valid, rsp_id, rsp_rdata, rsp_err
  );

  modport slv (
    input  req_valid, req_id, req_we, req_addr, req_wdata, rsp_ready,
    output req_ready, rsp_valid, rsp_id, rsp_rdata, rsp_err
  );

endinterface

`default_nettype wire

// ==== bus_isolate.sv ====
// ============================
// Isolation stage in front of the cluster path
// Drains pending transactions and answers with errors while isolated
// ============================
`timescale 1ns/1ps
`default_nettype none

module bus_isolate
  import cluster_bridge_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  isolate_i,
  output logic                  isolated_o,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  logic [SocIdWidth-1:0] req_id_i,
  input  logic                  req_we_i,
  input  logic [AddrWidth-1:0]  req_addr_i,
  input  logic [DataWidth-1:0]  req_wdata_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output logic [SocIdWidth-1:0] rsp_id_o,
  output logic [DataWidth-1:0]  rsp_rdata_o,
  output logic                  rsp_err_o,
  bridge_bus_if.mst             out
);

  logic [PendCntWidth-1:0] pend_q;
  logic                    isolated_q;
  logic                    loc_valid_q;
  logic [SocIdWidth-1:0]   loc_id_q;
  logic                    fwd_ok;
  logic                    fwd_req_hs;
  logic                    fwd_rsp_hs;
  logic                    loc_acc;
  logic                    loc_pop;

  // Open only when not isolating and no local answer is waiting
  assign fwd_ok = !isolate_i && !isolated_q && !loc_valid_q &&
                  (pend_q != PendCntWidth'(MaxPending));

  assign out.req_valid = req_valid_i && fwd_ok;
  assign out.req_id    = req_id_i;
  assign out.req_we    = req_we_i;
  assign out.req_addr  = req_addr_i;
  assign out.req_wdata = req_wdata_i;

  assign req_ready_o = isolated_q ? !loc_valid_q : (fwd_ok && out.req_ready);

  assign fwd_req_hs = out.req_valid && out.req_ready;
  assign fwd_rsp_hs = out.rsp_valid && out.rsp_ready;
  assign loc_acc    = isolated_q && req_valid_i && !loc_valid_q;
  assign loc_pop    = loc_valid_q && !out.rsp_valid && rsp_ready_i;

  // Forwarded responses win over the local error response
  assign out.rsp_ready = rsp_ready_i;
  assign rsp_valid_o   = out.rsp_valid || loc_valid_q;
  assign rsp_id_o      = out.rsp_valid ? out.rsp_id : loc_id_q;
  assign rsp_rdata_o   = out.rsp_valid ? out.rsp_rdata : '0;
  assign rsp_err_o     = out.rsp_valid ? out.rsp_err : 1'b1;

  assign isolated_o = isolated_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_q      <= '0;
      isolated_q  <= 1'b0;
      loc_valid_q <= 1'b0;
    end else begin
      case ({fwd_req_hs, fwd_rsp_hs})
        2'b10:   pend_q <= pend_q + 1'b1;
        2'b01:   pend_q <= pend_q - 1'b1;
        default: pend_q <= pend_q;
      endcase
      // No new forwards once isolate_i is high so the count only drains
      isolated_q <= isolate_i && (pend_q == '0);
      if (loc_acc) begin
        loc_valid_q <= 1'b1;
      end else if (loc_pop) begin
        loc_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (loc_acc) begin
      loc_id_q <= req_id_i;
    end
  end

  // Nothing leaves toward the cluster once isolation is reported
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    isolated_o |-> !out.req_valid && (pend_q == '0));

  // Downstream never answers more than was forwarded
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out.rsp_valid |-> (pend_q != '0));

endmodule

`default_nettype wire

// ==== id_remap.sv ====
// ============================
// Narrows wide SoC IDs to cluster IDs through a small table
// Restores the SoC ID on every response
// ============================
`timescale 1ns/1ps
`default_nettype none

module id_remap
  import cluster_bridge_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  bridge_bus_if.slv in,
  bridge_bus_if.mst out
);

  logic [SocIdWidth-1:0]     wide_id_q [MaxUniqIds];
  logic [TxnCntWidth-1:0]    cnt_q     [MaxUniqIds];
  logic                      hit;
  logic [ClusterIdWidth-1:0] hit_idx;
  logic                      free;
  logic [ClusterIdWidth-1:0] free_idx;
  logic [ClusterIdWidth-1:0] sel_idx;
  logic                      sel_ok;
  logic                      req_hs;
  logic                      rsp_hs;

  // Entry lookup for the incoming request
  always_comb begin
    hit      = 1'b0;
    hit_idx  = '0;
    free     = 1'b0;
    free_idx = '0;
    // Downward scan so the lowest free entry is the one kept
    for (int i = MaxUniqIds - 1; i >= 0; i--) begin
      if ((cnt_q[i] != '0) && (wide_id_q[i] == in.req_id)) begin
        hit     = 1'b1;
        hit_idx = ClusterIdWidth'(i);
      end
      if (cnt_q[i] == '0) begin
        free     = 1'b1;
        free_idx = ClusterIdWidth'(i);
      end
    end
  end

  // An ID that owns an entry stays there to keep same-ID ordering
  assign sel_idx = hit ? hit_idx : free_idx;
  assign sel_ok  = hit ? (cnt_q[hit_idx] != TxnCntWidth'(MaxTxnsPerId)) : free;

  // Request channel
  assign out.req_valid = in.req_valid && sel_ok;
  assign in.req_ready  = out.req_ready && sel_ok;
  assign out.req_id    = sel_idx;
  assign out.req_we    = in.req_we;
  assign out.req_addr  = in.req_addr;
  assign out.req_wdata = in.req_wdata;

  assign req_hs = out.req_valid && out.req_ready;

  // Response channel
  assign in.rsp_valid  = out.rsp_valid;
  assign out.rsp_ready = in.rsp_ready;
  assign in.rsp_id     = wide_id_q[out.rsp_id];
  assign in.rsp_rdata  = out.rsp_rdata;
  assign in.rsp_err    = out.rsp_err;

  assign rsp_hs = out.rsp_valid && out.rsp_ready;

  // Outstanding counts, an entry is free at zero
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MaxUniqIds; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < MaxUniqIds; i++) begin
        case ({req_hs && (sel_idx == ClusterIdWidth'(i)),
               rsp_hs && (out.rsp_id == ClusterIdWidth'(i))})
          2'b10:   cnt_q[i] <= cnt_q[i] + 1'b1;
          2'b01:   cnt_q[i] <= cnt_q[i] - 1'b1;
          default: cnt_q[i] <= cnt_q[i];
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      wide_id_q[sel_idx] <= in.req_id;
    end
  end

  // The cluster side only answers IDs that are still outstanding
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out.rsp_valid |-> (cnt_q[out.rsp_id] != '0));

endmodule

`default_nettype wire

// ==== cdc_src.sv ====
// ============================
// Source half of the cluster CDC
// Writes the request FIFO and reads the remote response FIFO
// ============================
`timescale 1ns/1ps
`default_nettype none

module cdc_src
  import cluster_bridge_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  bridge_bus_if.slv               in,
  // Request FIFO storage lives here
  output logic [ReqWordWidth-1:0] async_req_data_o,
  output logic [PtrWidth-1:0]     async_req_wptr_o,
  input  logic [PtrWidth-1:0]     async_req_rptr_i,
  // Response FIFO storage lives on the remote side
  input  logic [RspWordWidth-1:0] async_rsp_data_i,
  input  logic [PtrWidth-1:0]     async_rsp_wptr_i,
  output logic [PtrWidth-1:0]     async_rsp_rptr_o
);

  logic [ReqWordWidth-1:0] req_mem [FifoDepth];
  logic [PtrWidth-1:0]     req_wptr_bin_q;
  logic [PtrWidth-1:0]     req_wptr_gray_q;
  logic [PtrWidth-1:0]     req_rptr_sync1_q;
  logic [PtrWidth-1:0]     req_rptr_sync2_q;
  logic [PtrWidth-1:0]     req_rptr_bin;
  logic                    req_full;
  logic                    req_push;
  logic [PtrWidth-1:0]     rsp_rptr_bin_q;
  logic [PtrWidth-1:0]     rsp_rptr_gray_q;
  logic [PtrWidth-1:0]     rsp_wptr_sync1_q;
  logic [PtrWidth-1:0]     rsp_wptr_sync2_q;
  logic                    rsp_pop;

  function automatic logic [PtrWidth-1:0] bin2gray(input logic [PtrWidth-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic logic [PtrWidth-1:0] gray2bin(input logic [PtrWidth-1:0] gray);
    logic [PtrWidth-1:0] bin;
    bin[PtrWidth-1] = gray[PtrWidth-1];
    for (int i = PtrWidth - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // Full when the writer is one lap ahead of the synchronized reader
  assign req_full = (req_wptr_gray_q ==
                     {~req_rptr_sync2_q[PtrWidth-1 -: 2], req_rptr_sync2_q[PtrWidth-3:0]});

  assign in.req_ready = !req_full;
  assign req_push     = in.req_valid && !req_full;

  // Remote reader picks its slot directly
  assign req_rptr_bin     = gray2bin(async_req_rptr_i);
  assign async_req_data_o = req_mem[req_rptr_bin[LogDepth-1:0]];
  assign async_req_wptr_o = req_wptr_gray_q;

  always_ff @(posedge clk_i) begin
    if (req_push) begin
      req_mem[req_wptr_bin_q[LogDepth-1:0]] <= {in.req_id, in.req_we,
                                               in.req_addr, in.req_wdata};
    end
  end

  // Response side is empty while both gray pointers agree
  assign in.rsp_valid = (rsp_rptr_gray_q != rsp_wptr_sync2_q);
  assign {in.rsp_id, in.rsp_err, in.rsp_rdata} = async_rsp_data_i;
  assign rsp_pop          = in.rsp_valid && in.rsp_ready;
  assign async_rsp_rptr_o = rsp_rptr_gray_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_wptr_bin_q   <= '0;
      req_wptr_gray_q  <= '0;
      req_rptr_sync1_q <= '0;
      req_rptr_sync2_q <= '0;
      rsp_rptr_bin_q   <= '0;
      rsp_rptr_gray_q  <= '0;
      rsp_wptr_sync1_q <= '0;
      rsp_wptr_sync2_q <= '0;
    end else begin
      // Two-flop synchronizers for the remote pointers
      req_rptr_sync1_q <= async_req_rptr_i;
      req_rptr_sync2_q <= req_rptr_sync1_q;
      rsp_wptr_sync1_q <= async_rsp_wptr_i;
      rsp_wptr_sync2_q <= rsp_wptr_sync1_q;
      if (req_push) begin
        req_wptr_bin_q  <= req_wptr_bin_q + 1'b1;
        req_wptr_gray_q <= bin2gray(req_wptr_bin_q + 1'b1);
      end
      if (rsp_pop) begin
        rsp_rptr_bin_q  <= rsp_rptr_bin_q + 1'b1;
        rsp_rptr_gray_q <= bin2gray(rsp_rptr_bin_q + 1'b1);
      end
    end
  end

  // A slot is never overwritten before the remote side has read it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_push |-> (PtrWidth'(req_wptr_bin_q - req_rptr_bin) < PtrWidth'(FifoDepth)));

endmodule

`default_nettype wire

// ==== cluster_bridge.sv ====
// ============================
// SoC to integer cluster bridge
// Isolation then ID remap then the CDC source half
// ============================
`timescale 1ns/1ps
`default_nettype none

module cluster_bridge
  import cluster_bridge_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Isolation control
  input  logic                    isolate_i,
  output logic                    isolated_o,
  // SoC request
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  logic [SocIdWidth-1:0]   req_id_i,
  input  logic                    req_we_i,
  input  logic [AddrWidth-1:0]    req_addr_i,
  input  logic [DataWidth-1:0]    req_wdata_i,
  // SoC response
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i,
  output logic [SocIdWidth-1:0]   rsp_id_o,
  output logic [DataWidth-1:0]    rsp_rdata_o,
  output logic                    rsp_err_o,
  // Async request FIFO toward the cluster
  output logic [ReqWordWidth-1:0] async_req_data_o,
  output logic [PtrWidth-1:0]     async_req_wptr_o,
  input  logic [PtrWidth-1:0]     async_req_rptr_i,
  // Async response FIFO from the cluster
  input  logic [RspWordWidth-1:0] async_rsp_data_i,
  input  logic [PtrWidth-1:0]     async_rsp_wptr_i,
  output logic [PtrWidth-1:0]     async_rsp_rptr_o
);

  bridge_bus_if #(.IdWidth(SocIdWidth))     isolate_bus ();
  bridge_bus_if #(.IdWidth(ClusterIdWidth)) cluster_bus ();

  bus_isolate i_bus_isolate (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .isolate_i   ( isolate_i   ),
    .isolated_o  ( isolated_o  ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .req_id_i    ( req_id_i    ),
    .req_we_i    ( req_we_i    ),
    .req_addr_i  ( req_addr_i  ),
    .req_wdata_i ( req_wdata_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_id_o    ( rsp_id_o    ),
    .rsp_rdata_o ( rsp_rdata_o ),
    .rsp_err_o   ( rsp_err_o   ),
    .out         ( isolate_bus )
  );

  id_remap i_id_remap (
    .clk_i   ( clk_i       ),
    .rst_n_i ( rst_n_i     ),
    .in      ( isolate_bus ),
    .out     ( cluster_bus )
  );

  cdc_src i_cdc_src (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .in               ( cluster_bus      ),
    .async_req_data_o ( async_req_data_o ),
    .async_req_wptr_o ( async_req_wptr_o ),
    .async_req_rptr_i ( async_req_rptr_i ),
    .async_rsp_data_i ( async_rsp_data_i ),
    .async_rsp_wptr_i ( async_rsp_wptr_i ),
    .async_rsp_rptr_o ( async_rsp_rptr_o )
  );

endmodule

`default_nettype wire

// ==== tb_cluster_bridge.sv ====
// ============================
// Testbench for the SoC to cluster bridge
// Random traffic against a remote cluster model and a scoreboard
// ============================
`timescale 1ns/1ps
`default_nettype none

module tb_cluster_bridge
  import cluster_bridge_pkg::*;
();

  logic                    clk_i;
  logic                    rst_n_i;
  logic                    isolate_i;
  logic                    isolated_o;
  logic                    req_valid_i;
  logic                    req_ready_o;
  logic [SocIdWidth-1:0]   req_id_i;
  logic                    req_we_i;
  logic [AddrWidth-1:0]    req_addr_i;
  logic [DataWidth-1:0]    req_wdata_i;
  logic                    rsp_valid_o;
  logic                    rsp_ready_i;
  logic [SocIdWidth-1:0]   rsp_id_o;
  logic [DataWidth-1:0]    rsp_rdata_o;
  logic                    rsp_err_o;
  logic [ReqWordWidth-1:0] async_req_data_o;
  logic [PtrWidth-1:0]     async_req_wptr_o;
  logic [PtrWidth-1:0]     async_req_rptr_i;
  logic [RspWordWidth-1:0] async_rsp_data_i;
  logic [PtrWidth-1:0]     async_rsp_wptr_i;
  logic [PtrWidth-1:0]     async_rsp_rptr_o;

  // Scoreboard
  logic [SocIdWidth-1:0]   exp_id_q [$];
  logic [DataWidth-1:0]    exp_data_q [$];
  logic                    exp_err_q [$];
  logic [DataWidth-1:0]    ref_mem [16];

  // Remote cluster model
  logic [DataWidth-1:0]    rem_mem [16];
  logic [RspWordWidth-1:0] rsp_fifo [FifoDepth];
  logic [RspWordWidth-1:0] pend_word_q [$];
  int                      pend_due_q [$];
  logic [PtrWidth-1:0]     req_rd_bin;
  logic [PtrWidth-1:0]     rsp_wr_bin;
  logic [PtrWidth-1:0]     rsp_rd_bin;
  logic                    rand_ready;
  int                      max_delay;
  int                      cycle;
  int                      req_words;

  int                      val_errs;
  int                      tmo_errs;
  int                      oth_errs;
  int                      sent;
  int                      rcvd;

  function automatic logic [PtrWidth-1:0] to_gray(input logic [PtrWidth-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [PtrWidth-1:0] from_gray(input logic [PtrWidth-1:0] g);
    logic [PtrWidth-1:0] b;
    b = g;
    for (int i = 1; i < PtrWidth; i++) begin
      b = b ^ (g >> i);
    end
    return b;
  endfunction

  // Remote side presents the slot named by the bridge read pointer
  assign rsp_rd_bin       = from_gray(async_rsp_rptr_o);
  assign async_rsp_data_i = rsp_fifo[rsp_rd_bin[LogDepth-1:0]];

  cluster_bridge i_dut (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .isolate_i        ( isolate_i        ),
    .isolated_o       ( isolated_o       ),
    .req_valid_i      ( req_valid_i      ),
    .req_ready_o      ( req_ready_o      ),
    .req_id_i         ( req_id_i         ),
    .req_we_i         ( req_we_i         ),
    .req_addr_i       ( req_addr_i       ),
    .req_wdata_i      ( req_wdata_i      ),
    .rsp_valid_o      ( rsp_valid_o      ),
    .rsp_ready_i      ( rsp_ready_i      ),
    .rsp_id_o         ( rsp_id_o         ),
    .rsp_rdata_o      ( rsp_rdata_o      ),
    .rsp_err_o        ( rsp_err_o        ),
    .async_req_data_o ( async_req_data_o ),
    .async_req_wptr_o ( async_req_wptr_o ),
    .async_req_rptr_i ( async_req_rptr_i ),
    .async_rsp_data_i ( async_rsp_data_i ),
    .async_rsp_wptr_i ( async_rsp_wptr_i ),
    .async_rsp_rptr_o ( async_rsp_rptr_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Pops one request word per cycle, answers in order after a random delay
  always @(posedge clk_i) begin : remote_model
    logic [ReqWordWidth-1:0] word;
    logic [DataWidth-1:0]    rdata;
    #1;
    if (rst_n_i) begin
      cycle++;
      if (async_req_wptr_o != async_req_rptr_i) begin
        word = async_req_data_o;
        if (word[DataWidth+AddrWidth]) begin
          rem_mem[word[DataWidth+3:DataWidth]] = word[DataWidth-1:0];
          rdata = '0;
        end else begin
          rdata = rem_mem[word[DataWidth+3:DataWidth]];
        end
        pend_word_q.push_back({word[ReqWordWidth-1 -: ClusterIdWidth], 1'b0, rdata});
        pend_due_q.push_back(cycle + int'($urandom_range(0, max_delay)));
        req_rd_bin       = req_rd_bin + 1'b1;
        async_req_rptr_i = to_gray(req_rd_bin);
        req_words++;
      end
      if ((pend_word_q.size() > 0) && (cycle >= pend_due_q[0]) &&
          (PtrWidth'(rsp_wr_bin - rsp_rd_bin) != PtrWidth'(FifoDepth))) begin
        rsp_fifo[rsp_wr_bin[LogDepth-1:0]] = pend_word_q.pop_front();
        void'(pend_due_q.pop_front());
        rsp_wr_bin       = rsp_wr_bin + 1'b1;
        async_rsp_wptr_i = to_gray(rsp_wr_bin);
      end
    end
  end

  always @(posedge clk_i) begin
    #1;
    if (rst_n_i) begin
      rsp_ready_i = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
    end
  end

  // A handshake seen here completes at the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_id_q.size() == 0) begin
        $display("ERROR: response with id %h arrived with no request open", rsp_id_o);
        oth_errs++;
      end else begin
        check_rsp(rsp_id_o, rsp_rdata_o, rsp_err_o);
      end
      rcvd++;
    end
  end

  task automatic check_rsp(input logic [SocIdWidth-1:0] id,
                           input logic [DataWidth-1:0]  data,
                           input logic                  err);
    logic [SocIdWidth-1:0] e_id;
    logic [DataWidth-1:0]  e_data;
    logic                  e_err;
    e_id   = exp_id_q.pop_front();
    e_data = exp_data_q.pop_front();
    e_err  = exp_err_q.pop_front();
    if (id !== e_id) begin
      $display("FAILED rsp_id_o: expected %h, got %h", e_id, id);
      val_errs++;
    end
    if (data !== e_data) begin
      $display("FAILED rsp_rdata_o: expected %h, got %h", e_data, data);
      val_errs++;
    end
    if (err !== e_err) begin
      $display("FAILED rsp_err_o: expected %h, got %h", e_err, err);
      val_errs++;
    end
  endtask

  task automatic check_isolated(input logic exp);
    if (isolated_o !== exp) begin
      $display("FAILED isolated_o: expected %h, got %h", exp, isolated_o);
      val_errs++;
    end
  endtask

  // Called one step after a rising edge, returns at the same phase
  task automatic send_req(input logic [SocIdWidth-1:0] id, input logic we,
                          input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] wdata);
    int waited;
    waited      = 0;
    req_valid_i = 1'b1;
    req_id_i    = id;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    @(negedge clk_i);
    while (!req_ready_o && (waited < 1000)) begin
      waited++;
      @(negedge clk_i);
    end
    if (!req_ready_o) begin
      $display("ERROR: request with id %h was not accepted within 1000 cycles", id);
      tmo_errs++;
    end else begin
      exp_id_q.push_back(id);
      // Requests are only sent with isolate_i high once isolation is reached
      if (isolate_i) begin
        exp_data_q.push_back('0);
        exp_err_q.push_back(1'b1);
      end else if (we) begin
        ref_mem[addr[3:0]] = wdata;
        exp_data_q.push_back('0);
        exp_err_q.push_back(1'b0);
      end else begin
        exp_data_q.push_back(ref_mem[addr[3:0]]);
        exp_err_q.push_back(1'b0);
      end
      sent++;
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // The ID mask picks how many distinct SoC IDs are in play
  task automatic random_traffic(input int n, input logic [SocIdWidth-1:0] id_mask);
    for (int i = 0; i < n; i++) begin
      send_req(SocIdWidth'($urandom()) & id_mask, 1'($urandom_range(0, 1)),
               $urandom(), $urandom());
      if ($urandom_range(0, 3) == 0) begin
        idle(1);
      end
    end
  endtask

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while ((exp_id_q.size() != 0) && (waited < limit)) begin
      waited++;
      idle(1);
    end
    if (exp_id_q.size() != 0) begin
      $display("ERROR: %0d responses still missing after %0d cycles", exp_id_q.size(), limit);
      tmo_errs++;
    end
  endtask

  task automatic wait_isolated(input logic exp, input int limit);
    int waited;
    waited = 0;
    while ((isolated_o !== exp) && (waited < limit)) begin
      waited++;
      idle(1);
    end
    if (isolated_o !== exp) begin
      $display("ERROR: isolated_o did not reach %0d within %0d cycles", exp, limit);
      tmo_errs++;
    end else if (exp && (exp_id_q.size() != 0)) begin
      $display("ERROR: isolated_o rose with %0d transactions still open", exp_id_q.size());
      oth_errs++;
    end
  endtask

  initial begin
    int words;
    void'($urandom(52));
    {isolate_i, req_valid_i, req_we_i, rsp_ready_i, rand_ready} = '0;
    req_id_i         = '0;
    req_addr_i       = '0;
    req_wdata_i      = '0;
    async_req_rptr_i = '0;
    async_rsp_wptr_i = '0;
    {req_rd_bin, rsp_wr_bin} = '0;
    {val_errs, tmo_errs, oth_errs, sent, rcvd, cycle, req_words} = '0;
    max_delay = 4;
    for (int i = 0; i < 16; i++) begin
      ref_mem[i] = '0;
      rem_mem[i] = '0;
    end
    for (int i = 0; i < FifoDepth; i++) begin
      rsp_fifo[i] = '0;
    end
    rst_n_i = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check_isolated(1'b0);

    // Fill every memory word, then mixed traffic with many IDs
    for (int i = 0; i < 16; i++) begin
      send_req(SocIdWidth'($urandom()), 1'b1, {8'($urandom_range(0, 255)), 20'h0, 4'(i)},
               $urandom());
    end
    random_traffic(60, 6'h3F);
    // Few IDs repeated so entries are reused and per-ID limits stall
    random_traffic(60, 6'h21);
    random_traffic(40, 6'h10);
    wait_drain(2000);

    // Back-pressure on both sides
    rand_ready = 1'b1;
    max_delay  = 40;
    random_traffic(80, 6'h3F);
    wait_drain(8000);
    rand_ready = 1'b0;

    // Isolate with transactions in flight
    max_delay = 20;
    random_traffic(6, 6'h3F);
    isolate_i = 1'b1;
    wait_isolated(1'b1, 2000);
    repeat (10) begin
      idle(1);
      check_isolated(1'b1);
    end

    // Local error answers while isolated
    words = req_words;
    random_traffic(12, 6'h3F);
    wait_drain(500);
    if (req_words != words) begin
      $display("ERROR: remote side saw %0d request words while isolated", req_words - words);
      oth_errs++;
    end
    check_isolated(1'b1);
    isolate_i = 1'b0;
    max_delay = 4;
    wait_isolated(1'b0, 100);
    random_traffic(40, 6'h3F);
    wait_drain(2000);

    if (sent != rcvd) begin
      $display("ERROR: %0d requests accepted but %0d responses received", sent, rcvd);
      oth_errs++;
    end
    $display("Errors: %0d value, %0d timeout, %0d other", val_errs, tmo_errs, oth_errs);
    if ((val_errs + tmo_errs + oth_errs) == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (100000) @(posedge clk_i);
    $display("ERROR: run did not finish within 100000 cycles");
    $display("Errors: %0d value, %0d timeout, %0d other", val_errs, tmo_errs + 1, oth_errs);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
cluster_bridge_pkg.sv
bridge_bus_if.sv
bus_isolate.sv
id_remap.sv
cdc_src.sv
cluster_bridge.sv
tb_cluster_bridge.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_cluster_bridge -o tb_cluster_bridge \
  && ./obj_dir/tb_cluster_bridge > sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
